// File: compile.f
rtl/mem_pkg.sv
rtl/load_store_unit.sv
rtl/fetch_port.sv
rtl/bus_arbiter.sv
rtl/sram_slave.sv
rtl/mem_subsys.sv
testbench/mem_subsys_properties.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

// File: rtl/bus_arbiter.sv
// round-robin arbiter for the shared bus
// grant held from address request to the closing r or b handshake
// losing master sees its request masked and a zero response
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire mem_pkg::bus_req_t  lsu_bus_req,
	output mem_pkg::bus_rsp_t       lsu_bus_rsp,
	input  wire mem_pkg::bus_req_t  fetch_bus_req,
	output mem_pkg::bus_rsp_t       fetch_bus_rsp,
	output mem_pkg::bus_req_t       mem_bus_req,
	input  wire mem_pkg::bus_rsp_t  mem_bus_rsp
);

	// one-hot grant, bit 0 lsu, bit 1 fetch
	logic [1:0] gnt;
	logic       last_fetch;

	logic       lsu_want;
	logic       fetch_want;
	logic [1:0] pick;
	logic [1:0] sel;
	logic       xfer_done;

	always_comb begin
		lsu_want   = lsu_bus_req.arvalid | lsu_bus_req.awvalid;
		fetch_want = fetch_bus_req.arvalid | fetch_bus_req.awvalid;
		// on a tie favour whoever did not win last time
		if (lsu_want && fetch_want) begin
			pick = last_fetch ? 2'b01 : 2'b10;
		end else begin
			pick = {fetch_want, lsu_want};
		end
		// idle bus routes the new winner straight through
		sel = (gnt != 2'b00) ? gnt : pick;
	end

	always_comb begin
		mem_bus_req   = '0;
		lsu_bus_rsp   = '0;
		fetch_bus_rsp = '0;
		if (sel[0]) begin
			mem_bus_req = lsu_bus_req;
			lsu_bus_rsp = mem_bus_rsp;
		end else if (sel[1]) begin
			mem_bus_req   = fetch_bus_req;
			fetch_bus_rsp = mem_bus_rsp;
		end
	end

	assign xfer_done = (mem_bus_rsp.rvalid && mem_bus_req.rready) ||
		(mem_bus_rsp.bvalid && mem_bus_req.bready);

	always_ff @(posedge clk) begin
		if (reset) begin
			gnt        <= 2'b00;
			last_fetch <= 1'b0;
		end else if (gnt != 2'b00) begin
			if (xfer_done) begin
				gnt <= 2'b00;
			end
		end else if (pick != 2'b00) begin
			gnt        <= pick;
			last_fetch <= pick[1];
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_port.sv
// instruction fetch bus master
// reads one aligned word per request, returns it with an error flag
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               fetch_valid,
	output logic                    fetch_ready,
	input  wire mem_pkg::addr_t     fetch_pc,
	output logic                    instr_valid,
	input  wire logic               instr_ready,
	output mem_pkg::data_t          instr,
	output logic                    instr_err,
	output mem_pkg::bus_req_t       bus_req,
	input  wire mem_pkg::bus_rsp_t  bus_rsp
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		DONE
	} state_t;

	state_t state;
	addr_t  pc_q;
	logic   arvalid_q;
	logic   rready_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			fetch_ready <= 1'b1;
			instr_valid <= 1'b0;
			arvalid_q   <= 1'b0;
			rready_q    <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (fetch_valid && fetch_ready) begin
						// word aligned fetch address
						pc_q        <= {fetch_pc[31:2], 2'b00};
						fetch_ready <= 1'b0;
						arvalid_q   <= 1'b1;
						state       <= ADDR;
					end
				end
				ADDR: begin
					if (bus_rsp.arready) begin
						arvalid_q <= 1'b0;
						rready_q  <= 1'b1;
						state     <= DATA;
					end
				end
				DATA: begin
					if (bus_rsp.rvalid) begin
						rready_q    <= 1'b0;
						instr_err   <= (bus_rsp.rresp != RESP_OKAY);
						instr       <= (bus_rsp.rresp != RESP_OKAY) ? '0 : bus_rsp.rdata;
						instr_valid <= 1'b1;
						state       <= DONE;
					end
				end
				DONE: begin
					if (instr_ready) begin
						instr_valid <= 1'b0;
						fetch_ready <= 1'b1;
						state       <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// read only master, write channels stay quiet
	always_comb begin
		bus_req         = '0;
		bus_req.arvalid = arvalid_q;
		bus_req.araddr  = pc_q;
		bus_req.rready  = rready_q;
	end

endmodule

`default_nettype wire

// File: rtl/load_store_unit.sv
// load/store unit for the memory stage
// request latch and bus access FSM
// word-aligned bus address, shifted store data and byte strobes
// load data alignment with sign or zero extension
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               req_valid,
	output logic                    req_ready,
	input  wire mem_pkg::lsu_req_t  req,
	output logic                    rsp_valid,
	input  wire logic               rsp_ready,
	output mem_pkg::lsu_rsp_t       rsp,
	output mem_pkg::bus_req_t       bus_req,
	input  wire mem_pkg::bus_rsp_t  bus_rsp
);

	import mem_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOCK,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_RESP,
		DONE
	} state_t;

	state_t   state;
	lsu_req_t req_q;
	data_t    rdata_q;
	resp_t    resp_q;
	logic     arvalid_q;
	logic     awvalid_q;
	logic     wvalid_q;
	logic     rready_q;
	logic     bready_q;

	logic [1:0] offset;
	strb_t      size_strb;
	data_t      load_shifted;
	data_t      load_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= IDLE;
			req_ready <= 1'b1;
			rsp_valid <= 1'b0;
			arvalid_q <= 1'b0;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			rready_q  <= 1'b0;
			bready_q  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req_valid && req_ready) begin
						req_q     <= req;
						req_ready <= 1'b0;
						state     <= LOCK;
					end
				end
				// latched request starts the address phase
				LOCK: begin
					if (req_q.write) begin
						awvalid_q <= 1'b1;
						wvalid_q  <= 1'b1;
						state     <= WRITE_ADDR;
					end else begin
						arvalid_q <= 1'b1;
						state     <= READ_ADDR;
					end
				end
				READ_ADDR: begin
					if (bus_rsp.arready) begin
						arvalid_q <= 1'b0;
						rready_q  <= 1'b1;
						state     <= READ_DATA;
					end
				end
				READ_DATA: begin
					if (bus_rsp.rvalid) begin
						rready_q  <= 1'b0;
						rdata_q   <= bus_rsp.rdata;
						resp_q    <= bus_rsp.rresp;
						rsp_valid <= 1'b1;
						state     <= DONE;
					end
				end
				// slave takes address and data together
				WRITE_ADDR: begin
					if (bus_rsp.awready && bus_rsp.wready) begin
						awvalid_q <= 1'b0;
						wvalid_q  <= 1'b0;
						bready_q  <= 1'b1;
						state     <= WRITE_RESP;
					end
				end
				WRITE_RESP: begin
					if (bus_rsp.bvalid) begin
						bready_q  <= 1'b0;
						rdata_q   <= '0;
						resp_q    <= bus_rsp.bresp;
						rsp_valid <= 1'b1;
						state     <= DONE;
					end
				end
				DONE: begin
					if (rsp_ready) begin
						rsp_valid <= 1'b0;
						req_ready <= 1'b1;
						state     <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// byte offset inside the word
	assign offset = req_q.addr[1:0];

	always_comb begin
		case (req_q.op[2:1])
			2'b00:   size_strb = 4'b0001;
			2'b01:   size_strb = 4'b0011;
			default: size_strb = 4'b1111;
		endcase
	end

	always_comb begin
		bus_req         = '0;
		bus_req.arvalid = arvalid_q;
		bus_req.araddr  = {req_q.addr[31:2], 2'b00};
		bus_req.awvalid = awvalid_q;
		bus_req.awaddr  = {req_q.addr[31:2], 2'b00};
		bus_req.wvalid  = wvalid_q;
		bus_req.wdata   = req_q.data << {offset, 3'b000};
		bus_req.wstrb   = size_strb << offset;
		bus_req.rready  = rready_q;
		bus_req.bready  = bready_q;
	end

	// move the addressed byte or halfword down to bit 0
	assign load_shifted = rdata_q >> {offset, 3'b000};

	always_comb begin
		case (req_q.op)
			OP_LB:   load_ext = {{24{load_shifted[7]}}, load_shifted[7:0]};
			OP_LBU:  load_ext = {24'b0, load_shifted[7:0]};
			OP_LH:   load_ext = {{16{load_shifted[15]}}, load_shifted[15:0]};
			OP_LHU:  load_ext = {16'b0, load_shifted[15:0]};
			default: load_ext = load_shifted;
		endcase
	end

	always_comb begin
		rsp.err  = (resp_q != RESP_OKAY);
		rsp.data = (rsp.err || req_q.write) ? '0 : load_ext;
	end

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
// shared types for the memory subsystem
// address, data, strobe, operation and response types
// lsu request and response structs
// single-beat axi-lite style bus request and response structs
`default_nettype none

package mem_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [2:0]  mem_op_t;
	typedef logic [1:0]  resp_t;

	// load kinds
	localparam mem_op_t OP_LB  = 3'd0;
	localparam mem_op_t OP_LBU = 3'd1;
	localparam mem_op_t OP_LH  = 3'd2;
	localparam mem_op_t OP_LHU = 3'd3;
	localparam mem_op_t OP_LW  = 3'd4;
	// store kinds, told apart from loads by the write flag
	localparam mem_op_t OP_SB  = 3'd0;
	localparam mem_op_t OP_SH  = 3'd2;
	localparam mem_op_t OP_SW  = 3'd4;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	typedef struct packed {
		logic    write;
		addr_t   addr;
		data_t   data;
		mem_op_t op;
	} lsu_req_t;

	typedef struct packed {
		data_t data;
		logic  err;
	} lsu_rsp_t;

	// master to slave
	typedef struct packed {
		logic  arvalid;
		addr_t araddr;
		logic  awvalid;
		addr_t awaddr;
		logic  wvalid;
		data_t wdata;
		strb_t wstrb;
		logic  rready;
		logic  bready;
	} bus_req_t;

	// slave to master
	typedef struct packed {
		logic  arready;
		logic  rvalid;
		data_t rdata;
		resp_t rresp;
		logic  awready;
		logic  wready;
		logic  bvalid;
		resp_t bresp;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_subsys.sv
// memory subsystem top level
// load/store unit and fetch port sharing one bus to the sram
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
	parameter int MEM_WORDS  = 256,
	parameter int READ_DELAY = 2
) (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               lsu_req_valid,
	output logic                    lsu_req_ready,
	input  wire mem_pkg::lsu_req_t  lsu_req,
	output logic                    lsu_rsp_valid,
	input  wire logic               lsu_rsp_ready,
	output mem_pkg::lsu_rsp_t       lsu_rsp,
	input  wire logic               fetch_valid,
	output logic                    fetch_ready,
	input  wire mem_pkg::addr_t     fetch_pc,
	output logic                    instr_valid,
	input  wire logic               instr_ready,
	output mem_pkg::data_t          instr,
	output logic                    instr_err
);

	import mem_pkg::*;

	bus_req_t lsu_bus_req;
	bus_rsp_t lsu_bus_rsp;
	bus_req_t fetch_bus_req;
	bus_rsp_t fetch_bus_rsp;
	bus_req_t mem_bus_req;
	bus_rsp_t mem_bus_rsp;

	load_store_unit u_lsu (
		.clk       (clk),
		.reset     (reset),
		.req_valid (lsu_req_valid),
		.req_ready (lsu_req_ready),
		.req       (lsu_req),
		.rsp_valid (lsu_rsp_valid),
		.rsp_ready (lsu_rsp_ready),
		.rsp       (lsu_rsp),
		.bus_req   (lsu_bus_req),
		.bus_rsp   (lsu_bus_rsp)
	);

	fetch_port u_fetch (
		.clk         (clk),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.fetch_ready (fetch_ready),
		.fetch_pc    (fetch_pc),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.instr_err   (instr_err),
		.bus_req     (fetch_bus_req),
		.bus_rsp     (fetch_bus_rsp)
	);

	bus_arbiter u_arb (
		.clk           (clk),
		.reset         (reset),
		.lsu_bus_req   (lsu_bus_req),
		.lsu_bus_rsp   (lsu_bus_rsp),
		.fetch_bus_req (fetch_bus_req),
		.fetch_bus_rsp (fetch_bus_rsp),
		.mem_bus_req   (mem_bus_req),
		.mem_bus_rsp   (mem_bus_rsp)
	);

	sram_slave #(
		.MEM_WORDS  (MEM_WORDS),
		.READ_DELAY (READ_DELAY)
	) u_sram (
		.clk     (clk),
		.reset   (reset),
		.bus_req (mem_bus_req),
		.bus_rsp (mem_bus_rsp)
	);

endmodule

`default_nettype wire

// File: rtl/sram_slave.sv
// axi-lite style word memory slave
// read delay counter, byte strobed writes
// slave error and zero data for addresses beyond the array
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
	parameter int MEM_WORDS  = 256,
	parameter int READ_DELAY = 2
) (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire mem_pkg::bus_req_t  bus_req,
	output mem_pkg::bus_rsp_t       bus_rsp
);

	import mem_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = $clog2(READ_DELAY + 1);

	typedef logic [IDX_W-1:0] idx_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RWAIT,
		S_RDATA,
		S_BRESP
	} state_t;

	data_t mem [MEM_WORDS];

	state_t           state;
	logic [CNT_W-1:0] cnt;
	data_t            rdata_q;
	resp_t            rresp_q;
	resp_t            bresp_q;

	idx_t ar_idx;
	idx_t aw_idx;
	logic ar_ok;
	logic aw_ok;

	// word index from address bits above bit 1
	assign ar_idx = bus_req.araddr[IDX_W+1:2];
	assign aw_idx = bus_req.awaddr[IDX_W+1:2];
	assign ar_ok  = bus_req.araddr[31:2] < 30'(MEM_WORDS);
	assign aw_ok  = bus_req.awaddr[31:2] < 30'(MEM_WORDS);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			cnt   <= '0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			case (state)
				S_IDLE: begin
					if (bus_req.arvalid) begin
						// memory cannot change until this read is done
						rdata_q <= ar_ok ? mem[ar_idx] : '0;
						rresp_q <= ar_ok ? RESP_OKAY : RESP_SLVERR;
						cnt     <= CNT_W'(1);
						state   <= (READ_DELAY <= 1) ? S_RDATA : S_RWAIT;
					end else if (bus_req.awvalid && bus_req.wvalid) begin
						if (aw_ok) begin
							for (int b = 0; b < 4; b++) begin
								if (bus_req.wstrb[b]) begin
									mem[aw_idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
								end
							end
						end
						bresp_q <= aw_ok ? RESP_OKAY : RESP_SLVERR;
						state   <= S_BRESP;
					end
				end
				S_RWAIT: begin
					if (cnt == CNT_W'(READ_DELAY - 1)) begin
						state <= S_RDATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_RDATA: begin
					if (bus_req.rready) begin
						state <= S_IDLE;
					end
				end
				S_BRESP: begin
					if (bus_req.bready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_comb begin
		bus_rsp         = '0;
		bus_rsp.arready = (state == S_IDLE);
		bus_rsp.awready = (state == S_IDLE);
		bus_rsp.wready  = (state == S_IDLE);
		bus_rsp.rvalid  = (state == S_RDATA);
		bus_rsp.rdata   = rdata_q;
		bus_rsp.rresp   = rresp_q;
		bus_rsp.bvalid  = (state == S_BRESP);
		bus_rsp.bresp   = bresp_q;
	end

endmodule

`default_nettype wire

// File: testbench/mem_cases.txt
# port (L lsu, F fetch), write flag, op (0 b, 1 bu, 2 h, 3 hu, 4 w), address hex, data hex
# fetch lines ignore the write flag, op and data columns
L 1 4 00000100 13579bdf
L 1 4 00000010 a5b6c7d8
L 0 4 00000010 00000000
L 1 0 00000021 000000f1
L 1 2 00000022 000085aa
L 1 0 00000023 00000099
L 0 4 00000020 00000000
L 0 0 00000021 00000000
L 0 1 00000021 00000000
L 0 2 00000022 00000000
L 0 3 00000022 00000000
L 1 4 00000000 11223344
L 1 4 00000400 deadbeef
L 0 4 00000400 00000000
L 0 4 00000000 00000000
F 0 4 00000200 00000000
F 0 4 00000204 00000000
F 0 4 00000208 00000000
F 0 4 00000102 00000000
F 0 4 00000013 00000000
F 0 4 00000400 00000000
F 0 4 000003fe 00000000

// File: testbench/mem_checker.sv
// response checker for the memory subsystem
// byte array reference model of the sram contents
// per-port queues of accepted requests, compared at each response
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               lsu_req_valid,
	input  wire logic               lsu_req_ready,
	input  wire mem_pkg::lsu_req_t  lsu_req,
	input  wire logic               lsu_rsp_valid,
	input  wire logic               lsu_rsp_ready,
	input  wire mem_pkg::lsu_rsp_t  lsu_rsp,
	input  wire logic               fetch_valid,
	input  wire logic               fetch_ready,
	input  wire mem_pkg::addr_t     fetch_pc,
	input  wire logic               instr_valid,
	input  wire logic               instr_ready,
	input  wire mem_pkg::data_t     instr,
	input  wire logic               instr_err
);

	import mem_pkg::*;

	localparam int MODEL_BYTES = 1024;

	logic [7:0] model [MODEL_BYTES];
	lsu_req_t   lsu_q[$];
	addr_t      fetch_q[$];
	int         errors;
	int         checked;

	initial begin
		errors  = 0;
		checked = 0;
		for (int i = 0; i < MODEL_BYTES; i++) begin
			model[i] = 8'h00;
		end
	end

	function automatic data_t model_word(input addr_t a);
		int base;
		base = int'({a[31:2], 2'b00});
		return {model[base + 3], model[base + 2], model[base + 1], model[base]};
	endfunction

	// addressed bytes taken straight from the model and extended by the load kind
	function automatic data_t expect_load(input lsu_req_t r);
		int          a;
		logic [7:0]  lo_byte;
		logic [15:0] lo_half;
		a       = int'(r.addr);
		lo_byte = model[a];
		lo_half = {model[a + 1], model[a]};
		case (r.op)
			OP_LB:   return {{24{lo_byte[7]}}, lo_byte};
			OP_LBU:  return {24'h0, lo_byte};
			OP_LH:   return {{16{lo_half[15]}}, lo_half};
			OP_LHU:  return {16'h0, lo_half};
			default: return model_word(r.addr);
		endcase
	endfunction

	task automatic apply_store(input lsu_req_t r);
		int nbytes;
		nbytes = (r.op == OP_SB) ? 1 : (r.op == OP_SH) ? 2 : 4;
		if (r.addr >= MODEL_BYTES) begin
			return;
		end
		for (int b = 0; b < nbytes; b++) begin
			model[int'(r.addr) + b] = r.data[8*b +: 8];
		end
	endtask

	task automatic check_lsu();
		lsu_req_t r;
		logic     exp_err;
		data_t    exp_data;
		if (lsu_q.size() == 0) begin
			$display("lsu response arrived with no request outstanding");
			errors++;
			return;
		end
		r       = lsu_q.pop_front();
		exp_err = (r.addr >= MODEL_BYTES);
		checked++;
		if (lsu_rsp.err !== exp_err) begin
			$display("FAIL lsu_rsp.err: got %h expected %h (addr %h)",
				lsu_rsp.err, exp_err, r.addr);
			errors++;
		end
		if (!r.write) begin
			exp_data = exp_err ? '0 : expect_load(r);
			if (lsu_rsp.data !== exp_data) begin
				$display("FAIL lsu_rsp.data: got %h expected %h (addr %h op %h)",
					lsu_rsp.data, exp_data, r.addr, r.op);
				errors++;
			end
		end
	endtask

	task automatic check_fetch();
		addr_t pc;
		logic  exp_err;
		data_t exp_data;
		if (fetch_q.size() == 0) begin
			$display("fetch response arrived with no request outstanding");
			errors++;
			return;
		end
		pc       = fetch_q.pop_front();
		exp_err  = (pc >= MODEL_BYTES);
		exp_data = exp_err ? '0 : model_word(pc);
		checked++;
		if (instr_err !== exp_err) begin
			$display("FAIL instr_err: got %h expected %h (pc %h)", instr_err, exp_err, pc);
			errors++;
		end
		if (instr !== exp_data) begin
			$display("FAIL instr: got %h expected %h (pc %h)", instr, exp_data, pc);
			errors++;
		end
	endtask

	// handshakes seen at the falling edge complete on the next rising edge
	always @(negedge clk) begin
		if (!reset) begin
			if (lsu_req_valid && lsu_req_ready) begin
				lsu_q.push_back(lsu_req);
				if (lsu_req.write) begin
					apply_store(lsu_req);
				end
			end
			if (lsu_rsp_valid && lsu_rsp_ready) begin
				check_lsu();
			end
			if (fetch_valid && fetch_ready) begin
				fetch_q.push_back(fetch_pc);
			end
			if (instr_valid && instr_ready) begin
				check_fetch();
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/mem_subsys_properties.sv
// handshake assertions on the shared side of the bus arbiter
// valids held until ready, payload stable while waiting
// at most one master waiting on a response
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_properties (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire mem_pkg::bus_req_t  mem_bus_req,
	input  wire mem_pkg::bus_rsp_t  mem_bus_rsp,
	input  wire mem_pkg::bus_req_t  lsu_bus_req,
	input  wire mem_pkg::bus_req_t  fetch_bus_req
);

	int failures = 0;

	ar_held: assert property (@(posedge clk) disable iff (reset)
		mem_bus_req.arvalid && !mem_bus_rsp.arready |=> mem_bus_req.arvalid)
		else begin
			$error("arvalid dropped before arready");
			failures++;
		end

	aw_held: assert property (@(posedge clk) disable iff (reset)
		mem_bus_req.awvalid && !mem_bus_rsp.awready |=> mem_bus_req.awvalid)
		else begin
			$error("awvalid dropped before awready");
			failures++;
		end

	w_held: assert property (@(posedge clk) disable iff (reset)
		mem_bus_req.wvalid && !mem_bus_rsp.wready |=> mem_bus_req.wvalid)
		else begin
			$error("wvalid dropped before wready");
			failures++;
		end

	ar_stable: assert property (@(posedge clk) disable iff (reset)
		mem_bus_req.arvalid && !mem_bus_rsp.arready |=> $stable(mem_bus_req.araddr))
		else begin
			$error("araddr changed while arvalid waited");
			failures++;
		end

	aw_stable: assert property (@(posedge clk) disable iff (reset)
		mem_bus_req.awvalid && !mem_bus_rsp.awready |=>
		$stable(mem_bus_req.awaddr) && $stable(mem_bus_req.wdata) && $stable(mem_bus_req.wstrb))
		else begin
			$error("write payload changed while awvalid waited");
			failures++;
		end

	// transactions are serialized, so only one master sits in its response phase
	one_path: assert property (@(posedge clk) disable iff (reset)
		!((lsu_bus_req.rready || lsu_bus_req.bready) &&
		(fetch_bus_req.rready || fetch_bus_req.bready)))
		else begin
			$error("both masters waiting on a response at once");
			failures++;
		end

endmodule

bind bus_arbiter mem_subsys_properties u_props (
	.clk           (clk),
	.reset         (reset),
	.mem_bus_req   (mem_bus_req),
	.mem_bus_rsp   (mem_bus_rsp),
	.lsu_bus_req   (lsu_bus_req),
	.fetch_bus_req (fetch_bus_req)
);

`default_nettype wire

// File: testbench/tb_mem_subsys.sv
// testbench top for the memory subsystem
// clock and reset, case file reader, lsu and fetch request drivers
// random response stalls from an lfsr, closing error summary
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

	import mem_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic     clk;
	logic     reset;
	logic     lsu_req_valid;
	logic     lsu_req_ready;
	lsu_req_t lsu_req;
	logic     lsu_rsp_valid;
	logic     lsu_rsp_ready;
	lsu_rsp_t lsu_rsp;
	logic     fetch_valid;
	logic     fetch_ready;
	addr_t    fetch_pc;
	logic     instr_valid;
	logic     instr_ready;
	data_t    instr;
	logic     instr_err;

	lsu_req_t   lsu_cases[$];
	addr_t      fetch_cases[$];
	logic [7:0] lsu_lfsr;
	logic [7:0] fetch_lfsr;
	int         timeouts;
	int         file_errors;
	int         total;

	mem_subsys #(
		.MEM_WORDS  (256),
		.READ_DELAY (2)
	) DUT (
		.clk           (clk),
		.reset         (reset),
		.lsu_req_valid (lsu_req_valid),
		.lsu_req_ready (lsu_req_ready),
		.lsu_req       (lsu_req),
		.lsu_rsp_valid (lsu_rsp_valid),
		.lsu_rsp_ready (lsu_rsp_ready),
		.lsu_rsp       (lsu_rsp),
		.fetch_valid   (fetch_valid),
		.fetch_ready   (fetch_ready),
		.fetch_pc      (fetch_pc),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.instr         (instr),
		.instr_err     (instr_err)
	);

	mem_checker chk (
		.clk           (clk),
		.reset         (reset),
		.lsu_req_valid (lsu_req_valid),
		.lsu_req_ready (lsu_req_ready),
		.lsu_req       (lsu_req),
		.lsu_rsp_valid (lsu_rsp_valid),
		.lsu_rsp_ready (lsu_rsp_ready),
		.lsu_rsp       (lsu_rsp),
		.fetch_valid   (fetch_valid),
		.fetch_ready   (fetch_ready),
		.fetch_pc      (fetch_pc),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.instr         (instr),
		.instr_err     (instr_err)
	);

	always #50 clk = ~clk;

	// fibonacci lfsr with taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// two fresh bits give 0 to 3 stall cycles
	task automatic draw_stall(inout logic [7:0] state, output int stall);
		stall = 0;
		for (int b = 0; b < 2; b++) begin
			state = lfsr_step(state);
			stall = (stall << 1) | state[0];
		end
	endtask

	task automatic load_cases();
		int       fd;
		int       n;
		int       wr;
		int       op;
		byte      tag;
		string    line;
		addr_t    addr;
		data_t    data;
		lsu_req_t r;
		fd = $fopen("testbench/mem_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file testbench/mem_cases.txt");
			file_errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %d %d %h %h", tag, wr, op, addr, data);
			if (n != 5) begin
				$display("case file line could not be parsed: %s", line);
				file_errors++;
			end else if (tag == "L") begin
				r.write = wr[0];
				r.op    = op[2:0];
				r.addr  = addr;
				r.data  = data;
				lsu_cases.push_back(r);
			end else if (tag == "F") begin
				fetch_cases.push_back(addr);
			end else begin
				$display("case file line has an unknown port tag: %s", line);
				file_errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic send_lsu(input lsu_req_t op, output bit ok);
		int waited;
		int stall;
		ok = 1'b0;
		@(posedge clk);
		#1;
		lsu_req_valid = 1'b1;
		lsu_req       = op;
		waited        = 0;
		@(negedge clk);
		while (!lsu_req_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!lsu_req_ready) begin
			$display("lsu request at address %h was never accepted", op.addr);
			timeouts++;
			return;
		end
		@(posedge clk);
		#1;
		lsu_req_valid = 1'b0;
		waited        = 0;
		while (!lsu_rsp_valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!lsu_rsp_valid) begin
			$display("lsu response for address %h never arrived", op.addr);
			timeouts++;
			return;
		end
		draw_stall(lsu_lfsr, stall);
		repeat (stall) @(posedge clk);
		@(posedge clk);
		#1;
		lsu_rsp_ready = 1'b1;
		@(posedge clk);
		#1;
		lsu_rsp_ready = 1'b0;
		ok = 1'b1;
	endtask

	task automatic send_fetch(input addr_t pc, output bit ok);
		int waited;
		int stall;
		ok = 1'b0;
		@(posedge clk);
		#1;
		fetch_valid = 1'b1;
		fetch_pc    = pc;
		waited      = 0;
		@(negedge clk);
		while (!fetch_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!fetch_ready) begin
			$display("fetch request at pc %h was never accepted", pc);
			timeouts++;
			return;
		end
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		waited      = 0;
		while (!instr_valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!instr_valid) begin
			$display("fetch response for pc %h never arrived", pc);
			timeouts++;
			return;
		end
		draw_stall(fetch_lfsr, stall);
		repeat (stall) @(posedge clk);
		@(posedge clk);
		#1;
		instr_ready = 1'b1;
		@(posedge clk);
		#1;
		instr_ready = 1'b0;
		ok = 1'b1;
	endtask

	task automatic drive_lsu_stream();
		bit ok;
		foreach (lsu_cases[i]) begin
			send_lsu(lsu_cases[i], ok);
			if (!ok) begin
				break;
			end
		end
	endtask

	task automatic drive_fetch_stream();
		bit ok;
		foreach (fetch_cases[i]) begin
			send_fetch(fetch_cases[i], ok);
			if (!ok) begin
				break;
			end
		end
	endtask

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		lsu_req_valid = 1'b0;
		lsu_req       = '0;
		lsu_rsp_ready = 1'b0;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		instr_ready   = 1'b0;
		lsu_lfsr      = 8'd35;
		fetch_lfsr    = 8'd35;
		timeouts      = 0;
		file_errors   = 0;
		load_cases();
		total = lsu_cases.size() + fetch_cases.size();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			drive_lsu_stream();
			drive_fetch_stream();
		join
		repeat (5) @(posedge clk);
		$display("errors %0d, timeouts %0d, assertions %0d, file %0d, checked %0d of %0d",
			chk.errors, timeouts, DUT.u_arb.u_props.failures, file_errors,
			chk.checked, total);
		if (chk.errors == 0 && timeouts == 0 && DUT.u_arb.u_props.failures == 0 &&
			file_errors == 0 && total > 0 && chk.checked == total) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
